//--- hdl/clink_bridge_pkg.sv
package clink_bridge_pkg;

    ////////////////////////////////////////
    // Register map, byte offsets
    ////////////////////////////////////////
    localparam int unsigned REG_UART_DATA   = 'h00;  // TX on write, RX byte on read
    localparam int unsigned REG_CC          = 'h10;
    localparam int unsigned REG_RX_VALID    = 'h20;
    localparam int unsigned REG_CLINK_READY = 'h30;

    // Camera control lines, bit 0 is CC1
    localparam int unsigned CC_WIDTH = 4;

    // One UART character
    typedef logic [7:0] uart_byte_t;

    ////////////////////////////////////////
    // AXI response codes
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // Write side FSM
    typedef enum logic [2:0] {
        WR_IDLE,   // Waiting for AW
        WR_UART,   // Beats go to the transmitter
        WR_CC,     // Beats go to the CC lines
        WR_DRAIN,  // Unmapped, beats dropped
        WR_RESP    // B channel pending
    } write_state_t;

    // Read side FSM
    typedef enum logic [2:0] {
        RD_IDLE,         // Waiting for AR
        RD_UART,         // Waits for a received byte
        RD_RX_VALID,
        RD_CLINK_READY,
        RD_ERROR,        // Unmapped address
        RD_RESP          // R channel pending
    } read_state_t;

endpackage

//--- hdl/rx_byte_buffer.sv
`timescale 1ns/100ps

module rx_byte_buffer (
    input  logic                         s_axi_aclk,
    input  logic                         s_axi_aresetn,
    input  logic                         rx_ready,    // Strobe from the UART receiver
    input  clink_bridge_pkg::uart_byte_t rx_data,
    input  logic                         rx_release,  // Byte handed to the bus
    output clink_bridge_pkg::uart_byte_t rx_byte,
    output logic                         rx_pending
);

    logic rx_ready_q;  // Previous rx_ready for edge detect
    logic rx_rise;

    // Receiver may hold rx_ready for more than one cycle
    assign rx_rise = rx_ready & ~rx_ready_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rx_ready_q <= 1'b0;
            rx_pending <= 1'b0;
        end else begin
            rx_ready_q <= rx_ready;
            if (rx_rise) begin
                rx_pending <= 1'b1;  // New byte beats a release
            end else if (rx_release) begin
                rx_pending <= 1'b0;
            end
        end
    end

    // Data holder, an unread byte is simply overwritten
    always_ff @(posedge s_axi_aclk) begin
        if (rx_rise) begin
            rx_byte <= rx_data;
        end
    end

endmodule

//--- hdl/axi_write_ctrl.sv
`timescale 1ns/100ps

module axi_write_ctrl #(
    parameter int AXI_ADDR_WIDTH = 7,
    parameter int AXI_DATA_WIDTH = 128,
    parameter int AXI_ID_WIDTH   = 16
) (
    input  logic                                  s_axi_aclk,
    input  logic                                  s_axi_aresetn,
    // AW
    input  logic [AXI_ADDR_WIDTH-1:0]             awaddr,
    input  logic [AXI_ID_WIDTH-1:0]               awid,
    input  logic                                  awvalid,
    output logic                                  awready,
    // W
    input  logic [AXI_DATA_WIDTH-1:0]             wdata,
    input  logic                                  wlast,
    input  logic                                  wvalid,
    output logic                                  wready,
    // B
    output clink_bridge_pkg::axi_resp_t           bresp,
    output logic [AXI_ID_WIDTH-1:0]               bid,
    output logic                                  bvalid,
    input  logic                                  bready,
    // UART transmitter and camera control
    input  logic                                  tx_busy,
    output logic                                  tx_start,
    output clink_bridge_pkg::uart_byte_t          tx_data,
    output logic [clink_bridge_pkg::CC_WIDTH-1:0] cc
);

    import clink_bridge_pkg::*;

    write_state_t state;
    logic         aw_fire;
    logic         w_fire;

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;

    // Transmitter busy stalls the UART stream only
    // Busy shows one cycle after tx_start so that cycle waits too
    assign wready = ((state == WR_UART) && !tx_busy && !tx_start) ||
                    (state == WR_CC) ||
                    (state == WR_DRAIN);

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state    <= WR_IDLE;
            awready  <= 1'b0;
            bvalid   <= 1'b0;
            tx_start <= 1'b0;
            cc       <= '0;
        end else begin
            tx_start <= 1'b0;  // Single-cycle strobe
            case (state)
                WR_IDLE: begin
                    awready <= 1'b1;
                    if (aw_fire) begin
                        awready <= 1'b0;
                        if (awaddr == AXI_ADDR_WIDTH'(REG_UART_DATA)) begin
                            state <= WR_UART;
                        end else if (awaddr == AXI_ADDR_WIDTH'(REG_CC)) begin
                            state <= WR_CC;
                        end else begin
                            state <= WR_DRAIN;  // Swallow the burst first
                        end
                    end
                end
                WR_UART: begin
                    if (w_fire) begin
                        tx_start <= 1'b1;
                    end
                end
                WR_CC: begin
                    if (w_fire) begin
                        cc <= wdata[CC_WIDTH-1:0];  // Last beat sticks
                    end
                end
                WR_DRAIN: begin
                    // Nothing stored
                end
                WR_RESP: begin
                    if (bready) begin
                        bvalid  <= 1'b0;
                        awready <= 1'b1;
                        state   <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase

            // Burst end for every data state
            if (w_fire && wlast) begin
                bvalid <= 1'b1;
                state  <= WR_RESP;
            end
        end
    end

    ////////////////////////////////////////
    // Payload registers
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            bid <= awid;  // Echoed on B
            if ((awaddr == AXI_ADDR_WIDTH'(REG_UART_DATA)) ||
                (awaddr == AXI_ADDR_WIDTH'(REG_CC))) begin
                bresp <= RESP_OKAY;
            end else begin
                bresp <= RESP_SLVERR;
            end
        end
        if (w_fire && (state == WR_UART)) begin
            tx_data <= wdata[7:0];  // Low byte of the beat
        end
    end

endmodule

//--- hdl/axi_read_ctrl.sv
`timescale 1ns/100ps

module axi_read_ctrl #(
    parameter int AXI_ADDR_WIDTH = 7,
    parameter int AXI_DATA_WIDTH = 128,
    parameter int AXI_ID_WIDTH   = 16
) (
    input  logic                         s_axi_aclk,
    input  logic                         s_axi_aresetn,
    // AR
    input  logic [AXI_ADDR_WIDTH-1:0]    araddr,
    input  logic [AXI_ID_WIDTH-1:0]      arid,
    input  logic                         arvalid,
    output logic                         arready,
    // R
    output logic [AXI_DATA_WIDTH-1:0]    rdata,
    output clink_bridge_pkg::axi_resp_t  rresp,
    output logic [AXI_ID_WIDTH-1:0]      rid,
    output logic                         rlast,
    output logic                         rvalid,
    input  logic                         rready,
    // Receive buffer and status
    input  clink_bridge_pkg::uart_byte_t rx_byte,
    input  logic                         rx_pending,
    output logic                         rx_release,
    input  logic                         clink_ready
);

    import clink_bridge_pkg::*;

    read_state_t state;
    logic        ar_fire;
    logic        rd_is_uart;  // Current read targets REG_UART_DATA

    assign ar_fire = arvalid & arready;
    assign rlast   = rvalid;  // Single-beat reads only

    // Buffer freed once the byte is actually taken
    assign rx_release = rvalid & rready & rd_is_uart;

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state      <= RD_IDLE;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rd_is_uart <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    arready <= 1'b1;
                    if (ar_fire) begin
                        arready    <= 1'b0;
                        rd_is_uart <= 1'b0;
                        if (araddr == AXI_ADDR_WIDTH'(REG_UART_DATA)) begin
                            state      <= RD_UART;
                            rd_is_uart <= 1'b1;
                        end else if (araddr == AXI_ADDR_WIDTH'(REG_RX_VALID)) begin
                            state <= RD_RX_VALID;
                        end else if (araddr == AXI_ADDR_WIDTH'(REG_CLINK_READY)) begin
                            state <= RD_CLINK_READY;
                        end else begin
                            state <= RD_ERROR;
                        end
                    end
                end
                RD_UART: begin
                    if (rx_pending) begin  // Open-ended wait for a byte
                        rvalid <= 1'b1;
                        state  <= RD_RESP;
                    end
                end
                RD_RX_VALID, RD_CLINK_READY, RD_ERROR: begin
                    rvalid <= 1'b1;
                    state  <= RD_RESP;
                end
                RD_RESP: begin
                    if (rready) begin
                        rvalid  <= 1'b0;
                        arready <= 1'b1;
                        state   <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////
    // Read data and response
    ////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            rid <= arid;
        end
        case (state)
            RD_UART: begin
                rdata <= AXI_DATA_WIDTH'(rx_byte);
                rresp <= RESP_OKAY;
            end
            RD_RX_VALID: begin
                rdata <= AXI_DATA_WIDTH'(rx_pending);
                rresp <= RESP_OKAY;
            end
            RD_CLINK_READY: begin
                rdata <= AXI_DATA_WIDTH'(clink_ready);  // Level at sample time
                rresp <= RESP_OKAY;
            end
            RD_ERROR: begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
            default: begin
                // Hold while waiting on R
            end
        endcase
    end

endmodule

//--- hdl/clink_bridge_top.sv
`timescale 1ns/100ps

module clink_bridge_top #(
    parameter int AXI_ADDR_WIDTH = 7,
    parameter int AXI_DATA_WIDTH = 128,
    parameter int AXI_ID_WIDTH   = 16
) (
    input  logic                                  s_axi_aclk,
    input  logic                                  s_axi_aresetn,
    ////////////////////////////////////////
    // AXI4 slave
    ////////////////////////////////////////
    input  logic [AXI_ADDR_WIDTH-1:0]             awaddr,
    input  logic [AXI_ID_WIDTH-1:0]               awid,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [AXI_DATA_WIDTH-1:0]             wdata,
    input  logic                                  wlast,
    input  logic                                  wvalid,
    output logic                                  wready,
    output clink_bridge_pkg::axi_resp_t           bresp,
    output logic [AXI_ID_WIDTH-1:0]               bid,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [AXI_ADDR_WIDTH-1:0]             araddr,
    input  logic [AXI_ID_WIDTH-1:0]               arid,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [AXI_DATA_WIDTH-1:0]             rdata,
    output clink_bridge_pkg::axi_resp_t           rresp,
    output logic [AXI_ID_WIDTH-1:0]               rid,
    output logic                                  rlast,
    output logic                                  rvalid,
    input  logic                                  rready,
    ////////////////////////////////////////
    // CameraLink serial sideband
    ////////////////////////////////////////
    output logic                                  tx_start,
    output clink_bridge_pkg::uart_byte_t          tx_data,
    input  logic                                  tx_busy,
    input  logic                                  rx_ready,
    input  clink_bridge_pkg::uart_byte_t          rx_data,
    output logic [clink_bridge_pkg::CC_WIDTH-1:0] cc,         // Bit 0 is CC1
    input  logic                                  clink_ready
);

    import clink_bridge_pkg::*;

    uart_byte_t rx_byte;     // Held receive byte
    logic       rx_pending;
    logic       rx_release;  // From the read side

    rx_byte_buffer rx_byte_buffer_inst (
        .s_axi_aclk   (s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .rx_ready     (rx_ready),
        .rx_data      (rx_data),
        .rx_release   (rx_release),
        .rx_byte      (rx_byte),
        .rx_pending   (rx_pending)
    );

    // Write path, TX strobe and CC lines
    axi_write_ctrl #(
        .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
        .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
        .AXI_ID_WIDTH  (AXI_ID_WIDTH)
    ) axi_write_ctrl_inst (
        .s_axi_aclk   (s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .awaddr       (awaddr),
        .awid         (awid),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wlast        (wlast),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bid          (bid),
        .bvalid       (bvalid),
        .bready       (bready),
        .tx_busy      (tx_busy),
        .tx_start     (tx_start),
        .tx_data      (tx_data),
        .cc           (cc)
    );

    // Read path, independent of the write side
    axi_read_ctrl #(
        .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
        .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
        .AXI_ID_WIDTH  (AXI_ID_WIDTH)
    ) axi_read_ctrl_inst (
        .s_axi_aclk   (s_axi_aclk),
        .s_axi_aresetn(s_axi_aresetn),
        .araddr       (araddr),
        .arid         (arid),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rid          (rid),
        .rlast        (rlast),
        .rvalid       (rvalid),
        .rready       (rready),
        .rx_byte      (rx_byte),
        .rx_pending   (rx_pending),
        .rx_release   (rx_release),
        .clink_ready  (clink_ready)
    );

endmodule

//--- tb/tb_clink_bridge.sv
`timescale 1ns/100ps

module tb_clink_bridge;

    import clink_bridge_pkg::*;

    localparam int ADDR_W   = 7;
    localparam int DATA_W   = 128;
    localparam int ID_W     = 16;
    localparam int NUM_ROWS = 14;

    typedef enum logic [1:0] {
        OP_WRITE,  // AW, W beats, B
        OP_READ,   // Single AR/R
        OP_RX,     // Byte from the UART receiver
        OP_LEVEL   // New clink_ready level
    } op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [3:0]        beats;
        logic [DATA_W-1:0] data;       // First beat, RX byte or level
        axi_resp_t         exp_resp;
        logic [DATA_W-1:0] exp_rdata;
    } row_t;

    logic                s_axi_aclk;
    logic                s_axi_aresetn;
    logic [ADDR_W-1:0]   awaddr, araddr;
    logic [ID_W-1:0]     awid, bid, arid, rid;
    logic [DATA_W-1:0]   wdata, rdata;
    logic                awvalid, awready, wlast, wvalid, wready;
    logic                bvalid, bready, arvalid, arready;
    logic                rlast, rvalid, rready;
    axi_resp_t           bresp, rresp;
    logic                tx_start, tx_busy, rx_ready, clink_ready;
    uart_byte_t          tx_data, rx_data;
    logic [CC_WIDTH-1:0] cc;

    int         bus_errors  = 0;
    int         side_errors = 0;  // Counted by the sideband monitor
    int         seed        = 92;
    int         busy_len;
    uart_byte_t tx_log[$];        // Every byte seen on tx_start
    logic       uart_write_active = 1'b0;

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    row_t rows [NUM_ROWS] = '{
        '{OP_WRITE, ADDR_W'(REG_UART_DATA), 4'd3, 128'h41, RESP_OKAY, 128'h0},
        '{OP_WRITE, ADDR_W'(REG_CC), 4'd2, 128'hA5, RESP_OKAY, 128'h0},       // cc ends at 6
        '{OP_WRITE, ADDR_W'(REG_UART_DATA), 4'd5, 128'h30, RESP_OKAY, 128'h0},
        '{OP_RX, 7'h00, 4'd0, 128'h5C, RESP_OKAY, 128'h0},
        '{OP_READ, ADDR_W'(REG_RX_VALID), 4'd1, 128'h0, RESP_OKAY, 128'h1},
        '{OP_READ, ADDR_W'(REG_UART_DATA), 4'd1, 128'h0, RESP_OKAY, 128'h5C},
        '{OP_READ, ADDR_W'(REG_RX_VALID), 4'd1, 128'h0, RESP_OKAY, 128'h0},  // Released
        '{OP_LEVEL, 7'h00, 4'd0, 128'h1, RESP_OKAY, 128'h0},
        '{OP_READ, ADDR_W'(REG_CLINK_READY), 4'd1, 128'h0, RESP_OKAY, 128'h1},
        '{OP_LEVEL, 7'h00, 4'd0, 128'h0, RESP_OKAY, 128'h0},
        '{OP_READ, ADDR_W'(REG_CLINK_READY), 4'd1, 128'h0, RESP_OKAY, 128'h0},
        '{OP_WRITE, 7'h08, 4'd3, 128'h77, RESP_SLVERR, 128'h0},              // Unmapped
        '{OP_READ, 7'h44, 4'd1, 128'h0, RESP_SLVERR, 128'h0},                // Unmapped
        '{OP_WRITE, ADDR_W'(REG_CC), 4'd1, 128'h09, RESP_OKAY, 128'h0}
    };

    clink_bridge_top clink_bridge_top_inst (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #20 s_axi_aclk = ~s_axi_aclk;  // 40 ns period
    end

    // Beat k of a burst steps the low byte by 0x11
    function automatic logic [DATA_W-1:0] beat_word(input logic [DATA_W-1:0] base, input int k);
        return base + DATA_W'(k * 'h111);
    endfunction

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        $display("mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
        bus_errors++;
    endtask

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////
    task automatic write_burst(input row_t row, input logic [ID_W-1:0] id);
        int                  first;
        int                  n;
        int                  k;
        logic [CC_WIDTH-1:0] cc_before;
        logic [DATA_W-1:0]   last_word;
        uart_byte_t          sent[$];
        axi_resp_t           got_resp;
        logic [ID_W-1:0]     got_id;
        first     = tx_log.size();
        cc_before = cc;
        n         = int'(row.beats);
        uart_write_active = (row.addr == ADDR_W'(REG_UART_DATA));
        awaddr  = row.addr;
        awid    = id;
        awvalid = 1'b1;
        do @(negedge s_axi_aclk); while (!awready);
        @(posedge s_axi_aclk);
        #2;
        awvalid = 1'b0;
        for (k = 0; k < n; k++) begin
            last_word = beat_word(row.data, k);
            wdata  = last_word;
            wlast  = (k == n - 1);
            wvalid = 1'b1;
            sent.push_back(last_word[7:0]);
            do @(negedge s_axi_aclk); while (!wready);  // Stalls while busy
            @(posedge s_axi_aclk);
            #2;
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        do @(negedge s_axi_aclk); while (!bvalid);
        got_resp = bresp;
        got_id   = bid;
        repeat (2) @(negedge s_axi_aclk);  // B held off by low bready
        if (!bvalid || bresp !== got_resp || bid !== got_id) begin
            $display("B channel changed at time %0t while bready was low", $time);
            bus_errors++;
        end
        @(posedge s_axi_aclk);
        #2;
        bready = 1'b1;
        @(posedge s_axi_aclk);
        #2;
        bready = 1'b0;
        uart_write_active = 1'b0;
        if (got_resp !== row.exp_resp) report_mismatch("bresp", DATA_W'(got_resp),
                                                       DATA_W'(row.exp_resp));
        if (got_id !== id) report_mismatch("bid", DATA_W'(got_id), DATA_W'(id));
        if (row.addr == ADDR_W'(REG_UART_DATA)) begin
            if (tx_log.size() - first != n) begin
                report_mismatch("tx_start count", DATA_W'(tx_log.size() - first), DATA_W'(n));
            end else begin
                for (k = 0; k < n; k++) begin
                    if (tx_log[first + k] !== sent[k]) begin
                        report_mismatch("tx_data", DATA_W'(tx_log[first + k]), DATA_W'(sent[k]));
                    end
                end
            end
        end else if (tx_log.size() != first) begin  // CC and unmapped send nothing
            report_mismatch("tx_start count", DATA_W'(tx_log.size() - first), DATA_W'(0));
        end
        if (row.addr == ADDR_W'(REG_CC)) begin
            if (cc !== last_word[CC_WIDTH-1:0]) report_mismatch("cc", DATA_W'(cc),
                                                                DATA_W'(last_word[CC_WIDTH-1:0]));
        end else if (cc !== cc_before) begin
            report_mismatch("cc", DATA_W'(cc), DATA_W'(cc_before));
        end
    endtask

    task automatic read_register(input row_t row, input logic [ID_W-1:0] id);
        logic [DATA_W-1:0] got_data;
        axi_resp_t         got_resp;
        logic [ID_W-1:0]   got_id;
        logic              got_last;
        araddr  = row.addr;
        arid    = id;
        arvalid = 1'b1;
        do @(negedge s_axi_aclk); while (!arready);
        @(posedge s_axi_aclk);
        #2;
        arvalid = 1'b0;
        do @(negedge s_axi_aclk); while (!rvalid);  // UART data waits for a byte
        @(posedge s_axi_aclk);                      // One stalled edge first
        #2;
        rready = 1'b1;
        @(negedge s_axi_aclk);
        if (!rvalid) begin
            $display("rvalid dropped at time %0t before the R handshake", $time);
            bus_errors++;
        end
        got_data = rdata;
        got_resp = rresp;
        got_id   = rid;
        got_last = rlast;
        @(posedge s_axi_aclk);
        #2;
        rready = 1'b0;
        if (got_resp !== row.exp_resp) report_mismatch("rresp", DATA_W'(got_resp),
                                                       DATA_W'(row.exp_resp));
        if (got_data !== row.exp_rdata) report_mismatch("rdata", got_data, row.exp_rdata);
        if (got_id !== id) report_mismatch("rid", DATA_W'(got_id), DATA_W'(id));
        if (got_last !== 1'b1) report_mismatch("rlast", DATA_W'(got_last), DATA_W'(1));
    endtask

    task automatic receive_byte(input uart_byte_t value);
        rx_data  = value;
        rx_ready = 1'b1;  // Single-cycle strobe
        @(posedge s_axi_aclk);
        #2;
        rx_ready = 1'b0;
        @(posedge s_axi_aclk);
        #2;
    endtask

    ////////////////////////////////////////
    // UART transmitter model
    ////////////////////////////////////////
    initial begin
        tx_busy = 1'b0;
        forever begin
            @(negedge s_axi_aclk);
            if (s_axi_aresetn && tx_start) begin
                busy_len = 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
                @(posedge s_axi_aclk);
                #2;
                tx_busy = 1'b1;
                repeat (busy_len) @(posedge s_axi_aclk);
                #2;
                tx_busy = 1'b0;
            end
        end
    end

    // Sideband monitor
    always @(negedge s_axi_aclk) begin
        if (s_axi_aresetn) begin
            if (tx_start) tx_log.push_back(tx_data);
            if (tx_start && tx_busy) begin  // Transmitter cannot take this byte
                $display("tx_start at time %0t while tx_busy was high", $time);
                side_errors++;
            end
            if (uart_write_active && wvalid && wready && tx_busy) begin
                $display("W beat accepted at time %0t while tx_busy was high", $time);
                side_errors++;
            end
        end
    end

    // Watchdog
    initial begin
        repeat (NUM_ROWS * 300 + 4) @(posedge s_axi_aclk);
        $display("Timeout: tests did not complete within %0d cycles", NUM_ROWS * 300);
        $display("Errors: %0d bus, %0d sideband", bus_errors, side_errors);
        $display("Verification failed");
        $finish;
    end

    initial begin
        s_axi_aresetn = 1'b0;
        awaddr  = '0;
        awid    = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arid    = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        rx_ready    = 1'b0;
        rx_data     = '0;
        clink_ready = 1'b0;
        repeat (4) @(posedge s_axi_aclk);
        #2;
        s_axi_aresetn = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            case (rows[i].op)
                OP_WRITE: write_burst(rows[i], 16'h1000 + 16'(i * 'h111));
                OP_READ:  read_register(rows[i], 16'h2000 + 16'(i * 'h111));
                OP_RX:    receive_byte(rows[i].data[7:0]);
                default: begin
                    clink_ready = rows[i].data[0];
                    @(posedge s_axi_aclk);
                    #2;
                end
            endcase
        end
        repeat (2) @(posedge s_axi_aclk);
        $display("Errors: %0d bus, %0d sideband", bus_errors, side_errors);
        if (bus_errors + side_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
hdl/clink_bridge_pkg.sv
hdl/rx_byte_buffer.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/clink_bridge_top.sv
tb/tb_clink_bridge.sv

//--- Makefile
SIM      := verilator
TOP      := tb_clink_bridge
FILELIST := compile.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LOG      := sim.log
PASS_MSG := Verification passed

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
